// File: src/mc_bridge_defines.svh
`ifndef MC_BRIDGE_DEFINES_SVH
`define MC_BRIDGE_DEFINES_SVH

// processor side
`define PADDR_WIDTH      40

// network side widths
`define MC_DATA_WIDTH    32
`define MC_ADDR_WIDTH    28
`define X_CORD_WIDTH     6
`define Y_CORD_WIDTH     6
`define REG_ID_WIDTH     5

// outstanding network transactions and their id width
`define MAX_OUTSTANDING  4
`define TRANS_ID_WIDTH   2

// processor commands waiting for issue
`define CMD_FIFO_DEPTH   2

// tile word address carried in a tile region address
`define TILE_EPA_WIDTH   18

// local devices reachable from the network
`define CFG_DEV_BASE     40'h00_0020_0000
`define CLINT_DEV_BASE   40'h00_0030_0000

// device field of an incoming network address
`define IN_DEV_LSB       12
`define IN_DEV_WIDTH     4

`endif

// File: src/mc_bridge_pkg.sv
`include "mc_bridge_defines.svh"

package mc_bridge_pkg;

  typedef logic [`PADDR_WIDTH-1:0]       paddr_t;
  typedef logic [`MC_DATA_WIDTH-1:0]     mc_data_t;
  typedef logic [`MC_ADDR_WIDTH-1:0]     mc_addr_t;
  typedef logic [`X_CORD_WIDTH-1:0]      x_cord_t;
  typedef logic [`Y_CORD_WIDTH-1:0]      y_cord_t;
  typedef logic [`TRANS_ID_WIDTH-1:0]    trans_id_t;
  typedef logic [`REG_ID_WIDTH-1:0]      reg_id_t;
  typedef logic [`MC_DATA_WIDTH/8-1:0]   byte_mask_t;

  // uncached processor command kinds
  typedef enum logic [1:0] {
    e_mem_rd = 2'b00,
    e_mem_wr = 2'b01
  } msg_type_e;

  // access size in bytes
  typedef enum logic [1:0] {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10
  } msg_size_e;

  typedef enum logic [1:0] {
    e_remote_load  = 2'b00,
    e_remote_store = 2'b01
  } mc_op_e;

  typedef struct packed {
    msg_type_e msg_type;
    msg_size_e size;
    paddr_t    addr;
  } mem_header_s;

  // commands and responses in both directions
  typedef struct packed {
    mem_header_s header;
    mc_data_t    data;
  } mem_msg_s;

  typedef struct packed {
    mc_op_e     op;
    mc_addr_t   addr;
    mc_data_t   data;
    byte_mask_t mask;
    reg_id_t    reg_id;
    x_cord_t    src_x;
    y_cord_t    src_y;
    x_cord_t    x_cord;
    y_cord_t    y_cord;
  } mc_packet_s;

  // request arriving from the network
  typedef struct packed {
    logic     we;
    mc_addr_t addr;
    mc_data_t data;
  } mc_in_req_s;

  typedef struct packed {
    reg_id_t  reg_id;
    mc_data_t data;
  } mc_reply_s;

endpackage

// File: src/mc_cmd_fifo.sv
`include "mc_bridge_defines.svh"

module mc_cmd_fifo
  import mc_bridge_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  mem_msg_s cmd_i,
  input  logic     cmd_v_i,
  output logic     cmd_ready_o,
  output mem_msg_s head_o,
  output logic     head_v_o,
  input  logic     pop_i
);

  localparam int PTR_W = $clog2(`CMD_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`CMD_FIFO_DEPTH + 1);

  mem_msg_s         mem_r [`CMD_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [CNT_W-1:0] count_r;
  logic             push;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`CMD_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign cmd_ready_o = (count_r != CNT_W'(`CMD_FIFO_DEPTH));
  assign head_v_o    = (count_r != '0);
  assign head_o      = mem_r[rd_ptr_r];
  assign push        = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i)
    begin
      if (push)
        mem_r[wr_ptr_r] <= cmd_i;
    end

  always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        begin
          wr_ptr_r <= '0;
          rd_ptr_r <= '0;
          count_r  <= '0;
        end
      else
        begin
          if (push)
            wr_ptr_r <= next_ptr(wr_ptr_r);
          if (pop_i)
            rd_ptr_r <= next_ptr(rd_ptr_r);
          // occupancy moves only when one side acts alone
          if (push && !pop_i)
            count_r <= count_r + 1'b1;
          else if (pop_i && !push)
            count_r <= count_r - 1'b1;
        end
    end

  a_pop_needs_head: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> head_v_o)
    else $error("command popped from an empty fifo");

  // a command written into an empty fifo shows up at the head next cycle
  a_empty_bypass: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (push && !head_v_o) |=> (head_v_o && head_o == $past(cmd_i)))
    else $error("accepted command not at head on the following cycle");

endmodule

// File: src/mc_request_issue.sv
`include "mc_bridge_defines.svh"

module mc_request_issue
  import mc_bridge_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  mem_msg_s   head_i,
  input  logic       head_v_i,
  input  trans_id_t  id_i,
  input  logic       id_v_i,
  input  logic       out_ready_i,
  input  x_cord_t    my_x_i,
  input  y_cord_t    my_y_i,
  output logic       pop_o,
  output logic       alloc_o,
  output mc_packet_s out_packet_o,
  output logic       out_v_o
);

  // address field positions per region
  localparam int TILE_X_LSB = 2 + `TILE_EPA_WIDTH;
  localparam int TILE_Y_LSB = TILE_X_LSB + `X_CORD_WIDTH;
  localparam int VC_X_LSB   = 2 + `MC_ADDR_WIDTH;
  localparam int VC_ROW_BIT = VC_X_LSB + `X_CORD_WIDTH;

  paddr_t     addr;
  logic [1:0] region;
  byte_mask_t mask_base;
  logic       fire;

  assign addr   = head_i.header.addr;
  assign region = addr[`PADDR_WIDTH-1 -: 2];

  // one strobe pops the fifo, takes the id and sends the packet
  assign fire    = head_v_i & id_v_i & out_ready_i;
  assign pop_o   = fire;
  assign alloc_o = fire;
  assign out_v_o = fire;

  always_comb
    begin
      case (head_i.header.size)
        e_size_1: mask_base = 4'h1;
        e_size_2: mask_base = 4'h3;
        default:  mask_base = 4'hf;
      endcase
    end

  //////////////////////////////////////////////////////////////////////
  // packet build
  //////////////////////////////////////////////////////////////////////
  always_comb
    begin
      out_packet_o        = '0;
      out_packet_o.src_x  = my_x_i;
      out_packet_o.src_y  = my_y_i;
      out_packet_o.reg_id = reg_id_t'(id_i);
      out_packet_o.mask   = mask_base << addr[1:0];

      case (region)
        2'b11:
          begin
            out_packet_o.addr   = mc_addr_t'(addr[2 +: `TILE_EPA_WIDTH]);
            out_packet_o.x_cord = addr[TILE_X_LSB +: `X_CORD_WIDTH];
            out_packet_o.y_cord = addr[TILE_Y_LSB +: `Y_CORD_WIDTH];
          end
        2'b10:
          begin
            out_packet_o.addr   = addr[2 +: `MC_ADDR_WIDTH];
            out_packet_o.x_cord = addr[VC_X_LSB +: `X_CORD_WIDTH];
            // north or south cache row
            out_packet_o.y_cord = addr[VC_ROW_BIT] ? '1 : '0;
          end
        default:
          begin
            // host sits one row above this port
            out_packet_o.addr   = addr[2 +: `MC_ADDR_WIDTH];
            out_packet_o.x_cord = '0;
            out_packet_o.y_cord = my_y_i - 1'b1;
          end
      endcase

      if (head_i.header.msg_type == e_mem_wr)
        begin
          out_packet_o.op   = e_remote_store;
          out_packet_o.data = head_i.data;
        end
      else
        begin
          out_packet_o.op = e_remote_load;
        end
    end

  a_send_with_id: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_v_o |-> id_v_i)
    else $error("packet sent without a free transaction id");

  // a blocked head keeps its command until the network takes it
  a_head_waits: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (head_v_i && !out_v_o) |=> (head_v_i && $stable(head_i)))
    else $error("waiting command changed before issue");

endmodule

// File: src/mc_return_reorder.sv
`include "mc_bridge_defines.svh"

module mc_return_reorder
  import mc_bridge_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        alloc_i,
  input  mem_header_s header_i,
  output trans_id_t   id_o,
  output logic        id_v_o,
  input  mc_reply_s   reply_i,
  input  logic        reply_v_i,
  output mem_msg_s    resp_o,
  output logic        resp_v_o,
  input  logic        resp_yumi_i
);

  mem_header_s                 hdr_mem_r  [`MAX_OUTSTANDING];
  mc_data_t                    data_mem_r [`MAX_OUTSTANDING];
  logic [`MAX_OUTSTANDING-1:0] used_r;
  logic [`MAX_OUTSTANDING-1:0] done_r;
  trans_id_t                   alloc_ptr_r;
  trans_id_t                   rel_ptr_r;
  trans_id_t                   reply_id;

  assign reply_id = trans_id_t'(reply_i.reg_id);

  // next id is free once its previous owner has been released
  assign id_o   = alloc_ptr_r;
  assign id_v_o = ~used_r[alloc_ptr_r];

  // oldest entry leaves once its reply is in
  assign resp_v_o        = done_r[rel_ptr_r];
  assign resp_o.header   = hdr_mem_r[rel_ptr_r];
  assign resp_o.data     = data_mem_r[rel_ptr_r];

  //////////////////////////////////////////////////////////////////////
  // entry storage
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
    begin
      if (alloc_i)
        hdr_mem_r[alloc_ptr_r] <= header_i;
      if (reply_v_i)
        data_mem_r[reply_id] <= reply_i.data;
    end

  //////////////////////////////////////////////////////////////////////
  // pointers and entry state
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        begin
          used_r      <= '0;
          done_r      <= '0;
          alloc_ptr_r <= '0;
          rel_ptr_r   <= '0;
        end
      else
        begin
          if (alloc_i)
            begin
              used_r[alloc_ptr_r] <= 1'b1;
              alloc_ptr_r         <= alloc_ptr_r + 1'b1;
            end
          if (reply_v_i)
            done_r[reply_id] <= 1'b1;
          // release never hits the entry being allocated or written
          if (resp_yumi_i)
            begin
              used_r[rel_ptr_r] <= 1'b0;
              done_r[rel_ptr_r] <= 1'b0;
              rel_ptr_r         <= rel_ptr_r + 1'b1;
            end
        end
    end

  a_reply_tag: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    reply_v_i |-> (reply_i.reg_id < `MAX_OUTSTANDING
                   && used_r[reply_id] && !done_r[reply_id]))
    else $error("reply tag does not name an outstanding transaction");

  a_resp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (resp_v_o && !resp_yumi_i) |=> (resp_v_o && $stable(resp_o)))
    else $error("response dropped or changed before yumi");

endmodule

// File: src/mc_in_request.sv
`include "mc_bridge_defines.svh"

module mc_in_request
  import mc_bridge_pkg::*;
(
  input  mc_in_req_s in_req_i,
  input  logic       in_v_i,
  output logic       in_yumi_o,
  output mem_msg_s   io_cmd_o,
  output logic       io_cmd_v_o,
  input  logic       io_cmd_yumi_i,
  input  mem_msg_s   io_resp_i,
  input  logic       io_resp_v_i,
  output logic       io_resp_ready_o,
  output mc_data_t   returning_data_o,
  output logic       returning_v_o
);

  logic [`IN_DEV_WIDTH-1:0] dev;
  logic [`IN_DEV_LSB-1:0]   offset;

  assign dev    = in_req_i.addr[`IN_DEV_LSB +: `IN_DEV_WIDTH];
  assign offset = in_req_i.addr[`IN_DEV_LSB-1:0];

  //////////////////////////////////////////////////////////////////////
  // network request to processor command
  //////////////////////////////////////////////////////////////////////
  always_comb
    begin
      // only word accesses to the local devices
      io_cmd_o                 = '0;
      io_cmd_o.header.size     = e_size_4;
      io_cmd_o.header.msg_type = in_req_i.we ? e_mem_wr : e_mem_rd;
      io_cmd_o.data            = in_req_i.data;
      io_cmd_v_o               = 1'b0;
      in_yumi_o                = 1'b0;

      case (dev)
        4'h0:
          begin
            io_cmd_o.header.addr = `CFG_DEV_BASE + paddr_t'(offset);
            io_cmd_v_o           = in_v_i;
            in_yumi_o            = io_cmd_yumi_i;
          end
        4'h1:
          begin
            io_cmd_o.header.addr = `CLINT_DEV_BASE + paddr_t'(offset);
            io_cmd_v_o           = in_v_i;
            in_yumi_o            = io_cmd_yumi_i;
          end
        default:
          begin
            // unknown device, drop it
            in_yumi_o = in_v_i;
          end
      endcase
    end

  //////////////////////////////////////////////////////////////////////
  // processor response back to the network
  //////////////////////////////////////////////////////////////////////
  assign io_resp_ready_o = 1'b1;
  assign returning_v_o   = io_resp_v_i;

  always_comb
    begin
      case (io_resp_i.header.size)
        e_size_1: returning_data_o = mc_data_t'(io_resp_i.data[7:0]);
        e_size_2: returning_data_o = mc_data_t'(io_resp_i.data[15:0]);
        default:  returning_data_o = io_resp_i.data;
      endcase
    end

endmodule

// File: src/bp_to_mc_bridge.sv
module bp_to_mc_bridge
  import mc_bridge_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,

  // processor commands out to the network
  input  mem_msg_s   io_cmd_i,
  input  logic       io_cmd_v_i,
  output logic       io_cmd_ready_o,
  output mem_msg_s   io_resp_o,
  output logic       io_resp_v_o,
  input  logic       io_resp_yumi_i,

  // network requests in to the processor
  output mem_msg_s   io_cmd_o,
  output logic       io_cmd_v_o,
  input  logic       io_cmd_yumi_i,
  input  mem_msg_s   io_resp_i,
  input  logic       io_resp_v_i,
  output logic       io_resp_ready_o,

  // network side
  output mc_packet_s out_packet_o,
  output logic       out_v_o,
  input  logic       out_ready_i,
  input  mc_reply_s  returned_i,
  input  logic       returned_v_i,
  input  mc_in_req_s in_req_i,
  input  logic       in_v_i,
  output logic       in_yumi_o,
  output mc_data_t   returning_data_o,
  output logic       returning_v_o,

  input  x_cord_t    my_x_i,
  input  y_cord_t    my_y_i
);

  mem_msg_s  head_lo;
  logic      head_v_lo;
  logic      pop_lo;
  logic      alloc_lo;
  trans_id_t id_lo;
  logic      id_v_lo;

  mc_cmd_fifo u_cmd_fifo (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cmd_i       (io_cmd_i),
    .cmd_v_i     (io_cmd_v_i),
    .cmd_ready_o (io_cmd_ready_o),
    .head_o      (head_lo),
    .head_v_o    (head_v_lo),
    .pop_i       (pop_lo)
  );

  mc_request_issue u_issue (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .head_i       (head_lo),
    .head_v_i     (head_v_lo),
    .id_i         (id_lo),
    .id_v_i       (id_v_lo),
    .out_ready_i  (out_ready_i),
    .my_x_i       (my_x_i),
    .my_y_i       (my_y_i),
    .pop_o        (pop_lo),
    .alloc_o      (alloc_lo),
    .out_packet_o (out_packet_o),
    .out_v_o      (out_v_o)
  );

  mc_return_reorder u_reorder (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .alloc_i     (alloc_lo),
    .header_i    (head_lo.header),
    .id_o        (id_lo),
    .id_v_o      (id_v_lo),
    .reply_i     (returned_i),
    .reply_v_i   (returned_v_i),
    .resp_o      (io_resp_o),
    .resp_v_o    (io_resp_v_o),
    .resp_yumi_i (io_resp_yumi_i)
  );

  mc_in_request u_in_request (
    .in_req_i         (in_req_i),
    .in_v_i           (in_v_i),
    .in_yumi_o        (in_yumi_o),
    .io_cmd_o         (io_cmd_o),
    .io_cmd_v_o       (io_cmd_v_o),
    .io_cmd_yumi_i    (io_cmd_yumi_i),
    .io_resp_i        (io_resp_i),
    .io_resp_v_i      (io_resp_v_i),
    .io_resp_ready_o  (io_resp_ready_o),
    .returning_data_o (returning_data_o),
    .returning_v_o    (returning_v_o)
  );

endmodule

// File: verif/bridge_tb_model.svh
`ifndef BRIDGE_TB_MODEL_SVH
`define BRIDGE_TB_MODEL_SVH

// galois lfsr, one step per bit taken
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
logic [31:0] lfsr_q = 32'h648f;

function automatic logic [31:0] take_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++)
    begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
    end
  return v;
endfunction

function automatic msg_size_e to_size(input logic [1:0] code);
  case (code)
    2'd0:    return e_size_1;
    2'd1:    return e_size_2;
    default: return e_size_4;
  endcase
endfunction

function automatic mem_msg_s random_cmd();
  mem_msg_s    c;
  logic [31:0] r;
  r                     = take_bits(2);
  c.header.addr[39:38]  = r[1:0];
  r                     = take_bits(6);
  c.header.addr[37:32]  = r[5:0];
  c.header.addr[31:0]   = take_bits(32);
  r                     = take_bits(2);
  c.header.size         = to_size(r[1:0]);
  r                     = take_bits(1);
  c.header.msg_type     = r[0] ? e_mem_wr : e_mem_rd;
  c.data                = take_bits(32);
  return c;
endfunction

function automatic mc_in_req_s random_in_req();
  mc_in_req_s  q;
  logic [31:0] r;
  q.addr = mc_addr_t'(take_bits(28));
  r      = take_bits(2);
  // half of the requests go to device 0 or 1
  if (!r[1])
    q.addr[`IN_DEV_LSB +: 4] = {3'b000, r[0]};
  r      = take_bits(1);
  q.we   = r[0];
  q.data = take_bits(32);
  return q;
endfunction

function automatic mem_msg_s random_resp();
  mem_msg_s    m;
  logic [31:0] r;
  m             = '0;
  r             = take_bits(2);
  m.header.size = to_size(r[1:0]);
  m.data        = take_bits(32);
  return m;
endfunction

//////////////////////////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////////////////////////
function automatic mc_packet_s model_packet(input mem_msg_s cmd, input trans_id_t id,
                                            input x_cord_t mx, input y_cord_t my);
  mc_packet_s p;
  paddr_t     a;
  a        = cmd.header.addr;
  p        = '0;
  p.src_x  = mx;
  p.src_y  = my;
  p.reg_id = reg_id_t'(id);
  p.op     = (cmd.header.msg_type == e_mem_wr) ? e_remote_store : e_remote_load;
  if (cmd.header.msg_type == e_mem_wr)
    p.data = cmd.data;
  case (cmd.header.size)
    e_size_1: p.mask = 4'b0001 << a[1:0];
    e_size_2: p.mask = 4'b0011 << a[1:0];
    default:  p.mask = 4'b1111 << a[1:0];
  endcase
  if (a[39:38] == 2'b11)
    begin
      p.addr   = {10'd0, a[19:2]};
      p.x_cord = a[25:20];
      p.y_cord = a[31:26];
    end
  else if (a[39:38] == 2'b10)
    begin
      p.addr   = a[29:2];
      p.x_cord = a[35:30];
      p.y_cord = {6{a[36]}};
    end
  else
    begin
      p.addr   = a[29:2];
      p.x_cord = '0;
      p.y_cord = my - 6'd1;
    end
  return p;
endfunction

function automatic mem_msg_s model_io_cmd(input mc_in_req_s req);
  mem_msg_s m;
  m                 = '0;
  m.header.msg_type = req.we ? e_mem_wr : e_mem_rd;
  m.header.size     = e_size_4;
  if (req.addr[`IN_DEV_LSB +: 4] == 4'd0)
    m.header.addr = `CFG_DEV_BASE + {28'd0, req.addr[11:0]};
  else
    m.header.addr = `CLINT_DEV_BASE + {28'd0, req.addr[11:0]};
  m.data = req.data;
  return m;
endfunction

function automatic mc_data_t model_trim(input mem_msg_s r);
  case (r.header.size)
    e_size_1: return {24'd0, r.data[7:0]};
    e_size_2: return {16'd0, r.data[15:0]};
    default:  return r.data;
  endcase
endfunction

//////////////////////////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////////////////////////
task automatic check_packet(input mc_packet_s got, input mc_packet_s exp);
  if (got !== exp)
    report_error($sformatf("out_packet_o is %h, expected %h", got, exp));
endtask

task automatic check_resp(input mem_msg_s got, input mem_msg_s exp);
  if (got !== exp)
    report_error($sformatf("io_resp_o is %h, expected %h", got, exp));
endtask

task automatic check_io_cmd(input mem_msg_s got, input mem_msg_s exp);
  if (got !== exp)
    report_error($sformatf("io_cmd_o is %h, expected %h", got, exp));
endtask

task automatic check_data(input mc_data_t got, input mc_data_t exp);
  if (got !== exp)
    report_error($sformatf("returning_data_o is %h, expected %h", got, exp));
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp)
    report_error($sformatf("%s is %b, expected %b", name, got, exp));
endtask

`endif

// File: verif/bridge_tb.sv
`include "mc_bridge_defines.svh"

module bridge_tb
  import mc_bridge_pkg::*;
();

  localparam int NUM_CMDS    = 200;
  localparam int CYCLE_BOUND = 40;
  localparam int PERIOD      = 100;
  localparam int TIMEOUT     = (NUM_CMDS * CYCLE_BOUND + 8) * PERIOD;

  logic       clk_i, arst_n_i;
  mem_msg_s   io_cmd_i, io_resp_o, io_cmd_o, io_resp_i;
  logic       io_cmd_v_i, io_cmd_ready_o, io_resp_v_o, io_resp_yumi_i;
  logic       io_cmd_v_o, io_cmd_yumi_i, io_resp_v_i, io_resp_ready_o;
  mc_packet_s out_packet_o;
  logic       out_v_o, out_ready_i;
  mc_reply_s  returned_i;
  logic       returned_v_i;
  mc_in_req_s in_req_i;
  logic       in_v_i, in_yumi_o;
  mc_data_t   returning_data_o;
  logic       returning_v_o;
  x_cord_t    my_x_i;
  y_cord_t    my_y_i;

  // model of the fifo contents, the ids in allocation order and the unanswered ids
  mem_msg_s                    cmd_q [$];
  trans_id_t                   order_q [$];
  trans_id_t                   await_q [$];
  mem_header_s                 hdr_m [`MAX_OUTSTANDING];
  mc_data_t                    data_m [`MAX_OUTSTANDING];
  logic [`MAX_OUTSTANDING-1:0] replied;
  trans_id_t                   next_id;
  logic                        resp_v_pred;
  logic                        cmd_taken;
  int                          cmds_made;
  int                          resps_seen;

  `include "bridge_tb_model.svh"

  bp_to_mc_bridge dut (.*);

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "stopping at the first mismatch");
  endtask

  initial
    begin
      clk_i = 1'b0;
      forever #(PERIOD/2) clk_i = ~clk_i;
    end

  initial
    begin
      #(TIMEOUT);
      $display("watchdog expired with %0d of %0d responses seen", resps_seen, NUM_CMDS);
      $display("TB FAILED");
      $fatal(1, "simulation stopped by the watchdog");
    end

  //////////////////////////////////////////////////////////////////////
  // per cycle checks sampled at the falling edge
  //////////////////////////////////////////////////////////////////////
  task automatic observe_cycle();
    logic      exp_out_v;
    logic      supported;
    trans_id_t id;
    exp_out_v = (cmd_q.size() > 0) && (order_q.size() < `MAX_OUTSTANDING) && out_ready_i;
    check_flag("io_cmd_ready_o", io_cmd_ready_o, cmd_q.size() < `CMD_FIFO_DEPTH);
    check_flag("out_v_o", out_v_o, exp_out_v);
    check_flag("io_resp_v_o", io_resp_v_o, resp_v_pred);
    // oldest command answers first
    if (resp_v_pred)
      begin
        check_resp(io_resp_o, mem_msg_s'({hdr_m[order_q[0]], data_m[order_q[0]]}));
        if (io_resp_yumi_i)
          begin
            void'(order_q.pop_front());
            resps_seen++;
          end
      end
    if (out_v_o)
      begin
        check_packet(out_packet_o, model_packet(cmd_q[0], next_id, my_x_i, my_y_i));
        hdr_m[next_id]   = cmd_q[0].header;
        replied[next_id] = 1'b0;
        order_q.push_back(next_id);
        await_q.push_back(next_id);
        void'(cmd_q.pop_front());
        next_id++;
      end
    if (returned_v_i)
      begin
        id         = returned_i.reg_id[1:0];
        data_m[id] = returned_i.data;
        replied[id] = 1'b1;
      end
    cmd_taken = io_cmd_v_i && io_cmd_ready_o;
    if (cmd_taken)
      cmd_q.push_back(io_cmd_i);

    // incoming requests and returning data
    supported = (in_req_i.addr[`IN_DEV_LSB +: 4] < 4'd2);
    check_flag("io_cmd_v_o", io_cmd_v_o, in_v_i & supported);
    if (in_v_i && supported)
      check_io_cmd(io_cmd_o, model_io_cmd(in_req_i));
    check_flag("in_yumi_o", in_yumi_o, supported ? io_cmd_yumi_i : in_v_i);
    check_flag("io_resp_ready_o", io_resp_ready_o, 1'b1);
    check_flag("returning_v_o", returning_v_o, io_resp_v_i);
    if (io_resp_v_i)
      check_data(returning_data_o, model_trim(io_resp_i));
    // data written at this edge is presentable next cycle
    resp_v_pred = (order_q.size() > 0) && replied[order_q[0]];
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus and network responder driven at the rising edge
  //////////////////////////////////////////////////////////////////////
  task automatic drive_inputs();
    logic [31:0] r;
    mc_in_req_s  q;
    mc_reply_s   rp;
    logic        v;
    int          k;
    if (!io_cmd_v_i || cmd_taken)
      begin
        r = take_bits(2);
        if (cmds_made < NUM_CMDS && r[1:0] != 2'b00)
          begin
            io_cmd_i   <= random_cmd();
            io_cmd_v_i <= 1'b1;
            cmds_made++;
          end
        else
          io_cmd_v_i <= 1'b0;
      end
    r = take_bits(2);
    out_ready_i <= (r[1:0] != 2'b00);
    r = take_bits(1);
    io_resp_yumi_i <= resp_v_pred & r[0];

    // answer any unanswered packet
    r = take_bits(1);
    returned_v_i <= 1'b0;
    if (await_q.size() > 0 && r[0])
      begin
        r         = take_bits(3);
        k         = int'(r[2:0]) % await_q.size();
        rp.reg_id = reg_id_t'(await_q[k]);
        rp.data   = take_bits(32);
        await_q.delete(k);
        returned_i   <= rp;
        returned_v_i <= 1'b1;
      end

    q = random_in_req();
    r = take_bits(1);
    v = r[0];
    in_req_i <= q;
    in_v_i   <= v;
    r = take_bits(1);
    io_cmd_yumi_i <= v & (q.addr[`IN_DEV_LSB +: 4] < 4'd2) & r[0];
    io_resp_i <= random_resp();
    r = take_bits(1);
    io_resp_v_i <= r[0];
  endtask

  initial
    begin
      arst_n_i       = 1'b0;
      io_cmd_i       = '0;
      io_cmd_v_i     = 1'b0;
      io_resp_yumi_i = 1'b0;
      io_cmd_yumi_i  = 1'b0;
      io_resp_i      = '0;
      io_resp_v_i    = 1'b0;
      out_ready_i    = 1'b0;
      returned_i     = '0;
      returned_v_i   = 1'b0;
      in_req_i       = '0;
      in_v_i         = 1'b0;
      my_x_i         = 6'd3;
      my_y_i         = 6'd9;
      replied        = '0;
      next_id        = '0;
      resp_v_pred    = 1'b0;
      cmd_taken      = 1'b0;
      cmds_made      = 0;
      resps_seen     = 0;
      repeat (8) @(posedge clk_i);
      arst_n_i <= 1'b1;
      while (resps_seen < NUM_CMDS)
        begin
          @(negedge clk_i);
          observe_cycle();
          @(posedge clk_i);
          drive_inputs();
        end
      $display("TB PASSED");
      $finish;
    end

endmodule

// File: sources.f
+incdir+src
+incdir+verif
src/mc_bridge_pkg.sv
src/mc_cmd_fifo.sv
src/mc_request_issue.sv
src/mc_return_reorder.sv
src/mc_in_request.sv
src/bp_to_mc_bridge.sv
verif/bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the bridge testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sources.f --top-module bridge_tb -Mdir obj_dir -o bridge_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/bridge_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
